// File: calc_top.f
+incdir+sim
design/calc_types_pkg.sv
design/key_ctrl_pkg.sv
design/slot_timing_if.sv
design/key_debounce.sv
design/timing_chain.sv
design/entry_sequencer.sv
design/delay_line.sv
design/column_processor.sv
design/register_readout.sv
design/calc_top.sv
sim/calc_tb.sv

// File: design/calc_top.sv
/*
 * calculator top level
 * keyboard debounce, sequencer and recirculating add/subtract register loop
 */
`default_nettype none

module calc_top #(
    parameter int NUM_DIGITS = 13,
    parameter int KEY_DELAY  = 100
) (
    input  wire                                     clk,
    input  wire                                     i_reset,
    input  wire key_ctrl_pkg::key_t                 i_key,
    input  wire                                     i_key_down,
    output logic                                    o_kbd_ack,
    output logic                                    o_kbd_lock,
    output logic                                    o_overflow,
    output calc_types_pkg::bcd_t [NUM_DIGITS-1:0]   o_reg_x,
    output calc_types_pkg::bcd_t [NUM_DIGITS-1:0]   o_reg_y
);
    import calc_types_pkg::*;
    import key_ctrl_pkg::*;

    logic       execute;
    op_t        op;
    bcd_t       op_digit;
    bcd_t       line_head;
    bcd_t       line_tail;
    column_t    column;
    logic       column_valid;

    slot_timing_if #(.NUM_DIGITS(NUM_DIGITS)) u_slot_if ();

    key_debounce #(.KEY_DELAY(KEY_DELAY)) u_key_debounce (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_key_down (i_key_down),
        .o_kbd_ack  (o_kbd_ack)
    );

    timing_chain #(.NUM_DIGITS(NUM_DIGITS)) u_timing_chain (
        .clk     (clk),
        .i_reset (i_reset),
        .o_slot  (u_slot_if.source)
    );

    entry_sequencer u_entry_sequencer (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_key      (i_key),
        .i_kbd_ack  (o_kbd_ack),
        .i_slot     (u_slot_if.sink),
        .o_execute  (execute),
        .o_op       (op),
        .o_digit    (op_digit),
        .o_kbd_lock (o_kbd_lock)
    );

    // delay line and column latch form one full circulation
    delay_line #(.NUM_DIGITS(NUM_DIGITS)) u_delay_line (
        .clk     (clk),
        .i_reset (i_reset),
        .i_digit (line_tail),
        .o_digit (line_head)
    );

    column_processor #(.NUM_DIGITS(NUM_DIGITS)) u_column_processor (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_slot         (u_slot_if.sink),
        .i_execute      (execute),
        .i_op           (op),
        .i_digit        (op_digit),
        .i_line_digit   (line_head),
        .o_line_digit   (line_tail),
        .o_column       (column),
        .o_column_valid (column_valid),
        .o_overflow     (o_overflow)
    );

    register_readout #(.NUM_DIGITS(NUM_DIGITS)) u_register_readout (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_slot         (u_slot_if.sink),
        .i_column       (column),
        .i_column_valid (column_valid),
        .o_reg_x        (o_reg_x),
        .o_reg_y        (o_reg_y)
    );

endmodule

`default_nettype wire

// File: design/calc_types_pkg.sv
/*
 * calculator data types
 * digits, digit columns and register indices of the circulating stack
 */
`default_nettype none

package calc_types_pkg;

    // X, Y and two more stack registers share the loop
    localparam int NUM_REGS = 4;

    // one decimal digit
    typedef logic [3:0] bcd_t;

    // position of a register within a digit column
    typedef logic [1:0] reg_idx_t;

    // one digit of every register at the same digit position
    typedef bcd_t [NUM_REGS-1:0] column_t;

endpackage

`default_nettype wire

// File: design/column_processor.sv
/*
 * column processor
 * gathers each digit column, applies the command serially LSD first, drains it back
 */
`default_nettype none

module column_processor #(
    parameter int NUM_DIGITS = 13
) (
    input  wire                         clk,
    input  wire                         i_reset,
    slot_timing_if.sink                 i_slot,
    input  wire                         i_execute,
    input  wire key_ctrl_pkg::op_t      i_op,
    input  wire calc_types_pkg::bcd_t   i_digit,
    input  wire calc_types_pkg::bcd_t   i_line_digit,
    output calc_types_pkg::bcd_t        o_line_digit,
    output calc_types_pkg::column_t     o_column,
    output logic                        o_column_valid,
    output logic                        o_overflow
);
    import calc_types_pkg::*;
    import key_ctrl_pkg::*;

    localparam int COL_W = $clog2(NUM_DIGITS);

    // stack positions within a column
    localparam int REG_X = 0;
    localparam int REG_Y = 1;
    localparam int REG_Z = 2;
    localparam int REG_T = 3;

    column_t    latch_q;
    column_t    col_in;
    column_t    col_out;
    logic       first_col;
    logic       last_col;
    logic       carry_q;
    logic       carry_in;
    logic       carry_out;
    bcd_t       shift_q;
    bcd_t       shift_in;
    logic [4:0] sum;
    logic [4:0] diff;

    // in a column-last slot the line head is the top register of the column
    assign col_in = {i_line_digit, latch_q[NUM_REGS-2:0]};

    assign first_col = (i_slot.column == '0);
    assign last_col  = (i_slot.column == COL_W'(NUM_DIGITS - 1));

    // carry and shifted digit come from the previous column
    assign carry_in = first_col ? 1'b0 : carry_q;
    assign shift_in = first_col ? i_digit : shift_q;

    assign sum  = 5'(col_in[REG_Y]) + 5'(col_in[REG_X]) + 5'(carry_in);
    assign diff = 5'(col_in[REG_Y]) - 5'(col_in[REG_X]) - 5'(carry_in);

    always_comb begin
        col_out   = col_in;
        carry_out = 1'b0;
        if (i_execute) begin
            case (i_op)
                OP_DIGIT_NEW: col_out[REG_X] = first_col ? i_digit : 4'd0;
                OP_DIGIT:     col_out[REG_X] = shift_in;
                OP_ENTER: begin
                    col_out[REG_T] = col_in[REG_Z];
                    col_out[REG_Z] = col_in[REG_Y];
                    col_out[REG_Y] = col_in[REG_X];
                end
                OP_ADD: begin
                    carry_out      = (sum > 5'd9);
                    col_out[REG_X] = carry_out ? 4'(sum - 5'd10) : sum[3:0];
                    col_out[REG_Y] = col_in[REG_Z];
                    col_out[REG_Z] = col_in[REG_T];
                end
                OP_SUB: begin
                    // negative difference wraps to ten's complement with a borrow
                    carry_out      = diff[4];
                    col_out[REG_X] = carry_out ? 4'(diff + 5'd10) : diff[3:0];
                    col_out[REG_Y] = col_in[REG_Z];
                    col_out[REG_Z] = col_in[REG_T];
                end
                OP_CLR_X:   col_out[REG_X] = '0;
                OP_CLR_ALL: col_out = '0;
                default: ;
            endcase
        end
    end

    // each latch slot is drained to the line as the next column fills it
    always_ff @(posedge clk) begin
        if (i_reset) begin
            latch_q    <= '0;
            carry_q    <= 1'b0;
            o_overflow <= 1'b0;
        end else if (i_slot.column_last) begin
            latch_q <= col_out;
            if (i_execute) begin
                carry_q <= carry_out;
                if (last_col) begin
                    case (i_op)
                        OP_ADD, OP_SUB:       o_overflow <= carry_out;
                        OP_CLR_X, OP_CLR_ALL: o_overflow <= 1'b0;
                        default: ;
                    endcase
                end
            end
        end else begin
            latch_q[i_slot.reg_idx] <= i_line_digit;
        end
    end

    // X digit shifted up one position for digit entry
    always_ff @(posedge clk) begin
        if (i_slot.column_last && i_execute) begin
            shift_q <= col_in[REG_X];
        end
    end

    assign o_line_digit   = latch_q[i_slot.reg_idx];
    assign o_column       = col_out;
    assign o_column_valid = i_slot.column_last;

    a_bcd_digit : assert property (@(posedge clk) disable iff (i_reset)
        o_line_digit <= 4'd9)
        else $error("digit written to delay line is not BCD");

endmodule

`default_nettype wire

// File: design/delay_line.sv
/*
 * recirculating delay line
 * digit shift memory holding all but one column of the register loop
 */
`default_nettype none

module delay_line #(
    parameter int NUM_DIGITS = 13
) (
    input  wire                     clk,
    input  wire                     i_reset,
    input  wire calc_types_pkg::bcd_t i_digit,
    output calc_types_pkg::bcd_t    o_digit
);
    import calc_types_pkg::*;

    // the column latch in the processor supplies the remaining NUM_REGS slots
    localparam int DEPTH = NUM_REGS * (NUM_DIGITS - 1);

    bcd_t line_q [DEPTH];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                line_q[i] <= '0;
            end
        end else begin
            line_q[0] <= i_digit;
            for (int i = 1; i < DEPTH; i++) begin
                line_q[i] <= line_q[i - 1];
            end
        end
    end

    assign o_digit = line_q[DEPTH - 1];

endmodule

`default_nettype wire

// File: design/entry_sequencer.sv
/*
 * entry sequencer
 * latches an acknowledged key, waits for the word start and runs one circulation
 */
`default_nettype none

module entry_sequencer (
    input  wire                         clk,
    input  wire                         i_reset,
    input  wire key_ctrl_pkg::key_t     i_key,
    input  wire                         i_kbd_ack,
    slot_timing_if.sink                 i_slot,
    output logic                        o_execute,
    output key_ctrl_pkg::op_t           o_op,
    output calc_types_pkg::bcd_t        o_digit,
    output logic                        o_kbd_lock
);
    import calc_types_pkg::*;
    import key_ctrl_pkg::*;

    seq_state_t state_q;
    logic       new_entry_q;
    logic       key_is_digit;
    op_t        key_op;
    op_t        op_q;
    bcd_t       digit_q;

    assign key_is_digit = (i_key <= KEY_9);

    always_comb begin
        case (i_key)
            KEY_ENTER:   key_op = OP_ENTER;
            KEY_ADD:     key_op = OP_ADD;
            KEY_SUB:     key_op = OP_SUB;
            KEY_CLR_ENT: key_op = OP_CLR_X;
            KEY_CLR_ALL: key_op = OP_CLR_ALL;
            // a digit after a function key starts a fresh X
            default:     key_op = new_entry_q ? OP_DIGIT_NEW : OP_DIGIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_q     <= ST_IDLE;
            new_entry_q <= 1'b1;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    // acknowledges under the lock never reach here
                    if (i_kbd_ack) begin
                        state_q     <= ST_WAIT_WORD;
                        new_entry_q <= !key_is_digit;
                    end
                end
                ST_WAIT_WORD: begin
                    // the slot after word last is the word start
                    if (i_slot.word_last) begin
                        state_q <= ST_EXECUTE;
                    end
                end
                ST_EXECUTE: begin
                    if (i_slot.word_last) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // command latch
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && i_kbd_ack) begin
            op_q    <= key_op;
            digit_q <= bcd_t'(i_key);
        end
    end

    assign o_execute  = (state_q == ST_EXECUTE);
    assign o_kbd_lock = (state_q != ST_IDLE);
    assign o_op       = op_q;
    assign o_digit    = digit_q;

    // execution starts on the first slot of a word
    a_exec_aligned : assert property (@(posedge clk) disable iff (i_reset)
        $rose(o_execute) |-> i_slot.word_start)
        else $error("execute did not start at word start");

endmodule

`default_nettype wire

// File: design/key_ctrl_pkg.sv
/*
 * keyboard and sequencer encodings
 * key codes, column opcodes and command sequencer states
 */
`default_nettype none

package key_ctrl_pkg;

    // digit keys carry their own value as the code
    typedef enum logic [3:0] {
        KEY_0       = 4'd0,
        KEY_1       = 4'd1,
        KEY_2       = 4'd2,
        KEY_3       = 4'd3,
        KEY_4       = 4'd4,
        KEY_5       = 4'd5,
        KEY_6       = 4'd6,
        KEY_7       = 4'd7,
        KEY_8       = 4'd8,
        KEY_9       = 4'd9,
        KEY_ENTER   = 4'd10,
        KEY_ADD     = 4'd11,
        KEY_SUB     = 4'd12,
        KEY_CLR_ENT = 4'd13,
        KEY_CLR_ALL = 4'd14
    } key_t;

    // operation applied to every column over one circulation
    typedef enum logic [2:0] {
        OP_DIGIT,
        OP_DIGIT_NEW,
        OP_ENTER,
        OP_ADD,
        OP_SUB,
        OP_CLR_X,
        OP_CLR_ALL
    } op_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_WORD,
        ST_EXECUTE
    } seq_state_t;

endpackage

`default_nettype wire

// File: design/key_debounce.sv
/*
 * key debounce timer
 * gives one acknowledge pulse once a key has been held for KEY_DELAY cycles
 */
`default_nettype none

module key_debounce #(
    parameter int KEY_DELAY = 100
) (
    input  wire     clk,
    input  wire     i_reset,
    input  wire     i_key_down,
    output logic    o_kbd_ack
);

    localparam int CNT_W = $clog2(KEY_DELAY + 1);

    logic [CNT_W-1:0] hold_cnt;

    // counter parks at KEY_DELAY until the key comes up again
    always_ff @(posedge clk) begin
        if (i_reset) begin
            hold_cnt  <= '0;
            o_kbd_ack <= 1'b0;
        end else if (!i_key_down) begin
            hold_cnt  <= '0;
            o_kbd_ack <= 1'b0;
        end else begin
            if (hold_cnt != CNT_W'(KEY_DELAY)) begin
                hold_cnt <= hold_cnt + 1'b1;
            end
            o_kbd_ack <= (hold_cnt == CNT_W'(KEY_DELAY - 1));
        end
    end

    a_single_ack : assert property (@(posedge clk) disable iff (i_reset)
        o_kbd_ack |=> !o_kbd_ack)
        else $error("keyboard acknowledge held for more than one cycle");

endmodule

`default_nettype wire

// File: design/register_readout.sv
/*
 * register readout
 * collects the X and Y digits of each processed column into packed BCD words
 */
`default_nettype none

module register_readout #(
    parameter int NUM_DIGITS = 13
) (
    input  wire                                     clk,
    input  wire                                     i_reset,
    slot_timing_if.sink                             i_slot,
    input  wire calc_types_pkg::column_t            i_column,
    input  wire                                     i_column_valid,
    output calc_types_pkg::bcd_t [NUM_DIGITS-1:0]   o_reg_x,
    output calc_types_pkg::bcd_t [NUM_DIGITS-1:0]   o_reg_y
);

    // register 0 is X, register 1 is Y
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_reg_x <= '0;
            o_reg_y <= '0;
        end else if (i_column_valid) begin
            o_reg_x[i_slot.column] <= i_column[0];
            o_reg_y[i_slot.column] <= i_column[1];
        end
    end

endmodule

`default_nettype wire

// File: design/slot_timing_if.sv
/*
 * slot timing bus
 * current register and digit column of the loop, plus column and word markers
 */
`default_nettype none

interface slot_timing_if #(
    parameter int NUM_DIGITS = 13
);
    import calc_types_pkg::*;

    localparam int COL_W = $clog2(NUM_DIGITS);

    reg_idx_t           reg_idx;
    logic [COL_W-1:0]   column;
    logic               word_start;
    logic               column_last;
    logic               word_last;

    modport source (output reg_idx, column, word_start, column_last, word_last);
    modport sink   (input  reg_idx, column, word_start, column_last, word_last);

endinterface

`default_nettype wire

// File: design/timing_chain.sv
/*
 * timing chain
 * counts digit slots of the loop, register index fastest, then digit column
 */
`default_nettype none

module timing_chain #(
    parameter int NUM_DIGITS = 13
) (
    input  wire             clk,
    input  wire             i_reset,
    slot_timing_if.source   o_slot
);
    import calc_types_pkg::*;

    localparam int COL_W = $clog2(NUM_DIGITS);

    reg_idx_t           reg_idx_q;
    logic [COL_W-1:0]   column_q;
    logic               reg_last;
    logic               col_last;

    assign reg_last = (reg_idx_q == reg_idx_t'(NUM_REGS - 1));
    assign col_last = (column_q == COL_W'(NUM_DIGITS - 1));

    // free running, one slot per cycle
    always_ff @(posedge clk) begin
        if (i_reset) begin
            reg_idx_q <= '0;
            column_q  <= '0;
        end else if (reg_last) begin
            reg_idx_q <= '0;
            column_q  <= col_last ? '0 : column_q + 1'b1;
        end else begin
            reg_idx_q <= reg_idx_q + 1'b1;
        end
    end

    assign o_slot.reg_idx     = reg_idx_q;
    assign o_slot.column      = column_q;
    assign o_slot.word_start  = (reg_idx_q == '0) && (column_q == '0);
    assign o_slot.column_last = reg_last;
    assign o_slot.word_last   = reg_last && col_last;

    // a word ends and the next begins at register 0 of column 0
    a_word_wrap : assert property (@(posedge clk) disable iff (i_reset)
        o_slot.word_last |=> o_slot.word_start)
        else $error("word start does not follow word last");

endmodule

`default_nettype wire

// File: sim/calc_tb_table.svh
/*
 * calculator key sequence
 * one key per row with the X, Y and overflow lamp expected once the lock falls
 */
`ifndef CALC_TB_TABLE_SVH
`define CALC_TB_TABLE_SVH

// each row holds the key code, expected X and Y in BCD and the expected overflow
typedef struct packed {
    key_t                       key;
    logic [4*NUM_DIGITS-1:0]    x;
    logic [4*NUM_DIGITS-1:0]    y;
    logic                       ovf;
} row_t;

localparam int NUM_ROWS = 34;

row_t rows [NUM_ROWS] = '{
    // of fourteen digits the first one drops off the top
    '{KEY_1,       52'h0000000000001, 52'h0000000000000, 1'b0},
    '{KEY_2,       52'h0000000000012, 52'h0000000000000, 1'b0},
    '{KEY_3,       52'h0000000000123, 52'h0000000000000, 1'b0},
    '{KEY_4,       52'h0000000001234, 52'h0000000000000, 1'b0},
    '{KEY_5,       52'h0000000012345, 52'h0000000000000, 1'b0},
    '{KEY_6,       52'h0000000123456, 52'h0000000000000, 1'b0},
    '{KEY_7,       52'h0000001234567, 52'h0000000000000, 1'b0},
    '{KEY_8,       52'h0000012345678, 52'h0000000000000, 1'b0},
    '{KEY_9,       52'h0000123456789, 52'h0000000000000, 1'b0},
    '{KEY_0,       52'h0001234567890, 52'h0000000000000, 1'b0},
    '{KEY_1,       52'h0012345678901, 52'h0000000000000, 1'b0},
    '{KEY_2,       52'h0123456789012, 52'h0000000000000, 1'b0},
    '{KEY_3,       52'h1234567890123, 52'h0000000000000, 1'b0},
    '{KEY_4,       52'h2345678901234, 52'h0000000000000, 1'b0},
    '{KEY_CLR_ALL, 52'h0000000000000, 52'h0000000000000, 1'b0},
    // push 42 and 7, then 5 + 7 pops 42 into Y
    '{KEY_4,       52'h0000000000004, 52'h0000000000000, 1'b0},
    '{KEY_2,       52'h0000000000042, 52'h0000000000000, 1'b0},
    '{KEY_ENTER,   52'h0000000000042, 52'h0000000000042, 1'b0},
    '{KEY_7,       52'h0000000000007, 52'h0000000000042, 1'b0},
    '{KEY_ENTER,   52'h0000000000007, 52'h0000000000007, 1'b0},
    '{KEY_5,       52'h0000000000005, 52'h0000000000007, 1'b0},
    '{KEY_ADD,     52'h0000000000012, 52'h0000000000042, 1'b0},
    // 12 - 50 wraps to ten's complement
    '{KEY_ENTER,   52'h0000000000012, 52'h0000000000012, 1'b0},
    '{KEY_5,       52'h0000000000005, 52'h0000000000012, 1'b0},
    '{KEY_0,       52'h0000000000050, 52'h0000000000012, 1'b0},
    '{KEY_SUB,     52'h9999999999962, 52'h0000000000042, 1'b1},
    '{KEY_ENTER,   52'h9999999999962, 52'h9999999999962, 1'b1},
    '{KEY_CLR_ENT, 52'h0000000000000, 52'h9999999999962, 1'b0},
    // sum runs past thirteen digits
    '{KEY_5,       52'h0000000000005, 52'h9999999999962, 1'b0},
    '{KEY_0,       52'h0000000000050, 52'h9999999999962, 1'b0},
    '{KEY_ADD,     52'h0000000000012, 52'h0000000000042, 1'b1},
    '{KEY_CLR_ALL, 52'h0000000000000, 52'h0000000000000, 1'b0},
    '{KEY_ADD,     52'h0000000000000, 52'h0000000000000, 1'b0},
    '{KEY_8,       52'h0000000000008, 52'h0000000000000, 1'b0}
};

`endif

// File: sim/calc_tb.sv
/*
 * calculator testbench
 * presses keys from a table and checks X, Y, overflow and keyboard handshake
 */
`default_nettype none

module calc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import key_ctrl_pkg::*;

    localparam int NUM_DIGITS = 13;
    localparam int KEY_DELAY  = 100;
    localparam int LOOP_LEN   = 4 * NUM_DIGITS;

    `include "calc_tb_table.svh"

    localparam int TIMEOUT_CYCLES = NUM_ROWS * (KEY_DELAY + 2 * LOOP_LEN + 20);

    logic                       clk;
    logic                       i_reset;
    key_t                       i_key;
    logic                       i_key_down;
    logic                       o_kbd_ack;
    logic                       o_kbd_lock;
    logic                       o_overflow;
    logic [4*NUM_DIGITS-1:0]    o_reg_x;
    logic [4*NUM_DIGITS-1:0]    o_reg_y;

    int cycle_count = 0;
    int ack_count = 0;

    calc_top #(.NUM_DIGITS(NUM_DIGITS), .KEY_DELAY(KEY_DELAY)) u_calc_top (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_key      (i_key),
        .i_key_down (i_key_down),
        .o_kbd_ack  (o_kbd_ack),
        .o_kbd_lock (o_kbd_lock),
        .o_overflow (o_overflow),
        .o_reg_x    (o_reg_x),
        .o_reg_y    (o_reg_y)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        $display("Error: time %0d ns, %s expected %0h, actual %0h",
                 $time, name, expected, actual);
        stop_with_failure();
    endtask

    task automatic range_error(input string name, input int lo, input int hi,
                               input int actual);
        $display("Error: time %0d ns, %s expected %0d to %0d, actual %0d",
                 $time, name, lo, hi, actual);
        stop_with_failure();
    endtask

    // step to 1 ns after the next rising edge
    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    // counts acknowledge cycles as seen on each edge
    always @(posedge clk) begin
        if (!i_reset && o_kbd_ack) begin
            ack_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the key sequence did not finish", cycle_count);
            stop_with_failure();
        end
    end

    // hold a key until acknowledged, release it and wait out the lock
    task automatic press_key(input key_t key);
        int press_cycles;
        int lock_cycles;
        i_key      = key;
        i_key_down = 1'b1;
        wait_cycle();
        press_cycles = 1;
        while (!o_kbd_ack && press_cycles <= KEY_DELAY) begin
            wait_cycle();
            press_cycles++;
        end
        assert (o_kbd_ack) else value_error("o_kbd_ack", 1, o_kbd_ack);
        assert (press_cycles == KEY_DELAY)
            else value_error("key to o_kbd_ack cycles", KEY_DELAY, press_cycles);
        i_key_down = 1'b0;
        wait_cycle();
        assert (!o_kbd_ack) else value_error("o_kbd_ack", 0, o_kbd_ack);
        assert (o_kbd_lock) else value_error("o_kbd_lock", 1, o_kbd_lock);
        lock_cycles = 1;
        while (o_kbd_lock && lock_cycles <= 2 * LOOP_LEN) begin
            wait_cycle();
            if (o_kbd_lock) begin
                lock_cycles++;
            end
        end
        assert (!o_kbd_lock) else value_error("o_kbd_lock", 0, o_kbd_lock);
        assert (lock_cycles >= LOOP_LEN + 1 && lock_cycles <= 2 * LOOP_LEN)
            else range_error("o_kbd_lock high cycles", LOOP_LEN + 1, 2 * LOOP_LEN, lock_cycles);
    endtask

    task automatic check_row(input int row);
        assert (o_reg_x == rows[row].x) else value_error("o_reg_x", rows[row].x, o_reg_x);
        assert (o_reg_y == rows[row].y) else value_error("o_reg_y", rows[row].y, o_reg_y);
        assert (o_overflow == rows[row].ovf)
            else value_error("o_overflow", rows[row].ovf, o_overflow);
        assert (ack_count == row + 1)
            else value_error("o_kbd_ack pulse count", row + 1, ack_count);
    endtask

    initial begin
        i_reset    = 1'b1;
        i_key      = KEY_0;
        i_key_down = 1'b0;
        repeat (10) wait_cycle();
        i_reset = 1'b0;
        wait_cycle();

        // everything clear out of reset
        assert (o_reg_x == '0) else value_error("o_reg_x", 0, o_reg_x);
        assert (o_reg_y == '0) else value_error("o_reg_y", 0, o_reg_y);
        assert (!o_overflow) else value_error("o_overflow", 0, o_overflow);
        assert (!o_kbd_lock) else value_error("o_kbd_lock", 0, o_kbd_lock);

        for (int i = 0; i < NUM_ROWS; i++) begin
            press_key(rows[i].key);
            check_row(i);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire
